// File: flist.f
source/cam_pkg.sv
source/sccb_master.sv
source/cam_cfg.sv
source/pixel_capture.sv
source/pixel_fifo.sv
source/cam_top.sv
verif/cam_checker.sv
verif/cam_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --top-module cam_tb -f flist.f -o cam_sim \
	&& ./obj_dir/cam_sim | tee /dev/stderr | grep -q "^Test passed$" \
	&& echo "simulation ok" \
	|| { echo "simulation failed"; exit 1; }

// File: source/cam_cfg.sv
`timescale 1ns/10ps

module cam_cfg (
	input  logic clk_75MHz,
	input  logic db_rstn,
	input  logic i_scl,    // pin levels
	input  logic i_sda,
	output logic o_scl,    // 1 releases
	output logic o_sda,
	output logic o_done    // sticky until reset
);
	import cam_pkg::*;

	cfg_state_t state;

	logic [CFG_IDX_W-1:0] idx;   // current table entry
	logic                 cmd_stb;
	logic [7:0]           cmd_reg;
	logic [7:0]           cmd_val;
	logic                 xfer_done;
	logic                 bus_idle;

	assign cmd_reg  = CFG_TABLE[idx][15:8];
	assign cmd_val  = CFG_TABLE[idx][7:0];
	assign bus_idle = i_scl & i_sda;  // nobody holding either line

	always_ff @(posedge clk_75MHz or negedge db_rstn) begin
		if (!db_rstn) begin
			state   <= BOOT;
			idx     <= '0;
			cmd_stb <= 1'b0;
			o_done  <= 1'b0;
		end else begin
			cmd_stb <= 1'b0;
			case (state)
				BOOT: begin
					idx   <= '0;
					state <= ISSUE;  // runs once by itself
				end
				ISSUE: begin
					if (bus_idle) begin
						cmd_stb <= 1'b1;
						state   <= WAIT;
					end
				end
				WAIT: begin
					if (xfer_done) begin
						if (idx == CFG_LAST) begin
							state  <= DONE;
							o_done <= 1'b1;
						end else begin
							idx   <= idx + 1'b1;
							state <= ISSUE;
						end
					end
				end
				DONE: o_done <= 1'b1;  // stays here
				default: state <= BOOT;
			endcase
		end
	end

	sccb_master sccb_i (
		.clk_75MHz   (clk_75MHz),
		.db_rstn     (db_rstn),
		.i_cmd_stb   (cmd_stb),
		.i_cmd_reg   (cmd_reg),
		.i_cmd_val   (cmd_val),
		.i_scl       (i_scl),
		.o_scl       (o_scl),
		.o_sda       (o_sda),
		.o_xfer_done (xfer_done)
	);

endmodule

// File: source/cam_pkg.sv
package cam_pkg;

	// pixel word and fifo sizing
	localparam int PIX_W      = 12;               // packed rgb444
	localparam int FIFO_PTR_W = 4;                // fifo address bits
	localparam int FIFO_DEPTH = 1 << FIFO_PTR_W;  // 16 words

	// fill level at or below this counts as almost empty
	localparam logic [FIFO_PTR_W:0] ALMOST_EMPTY_OFS = 2;

	// sccb bit timing, one scl period is four quarters
	localparam int SCL_QTR = 4;                   // clk_75MHz cycles per quarter, short for sim
	localparam int QCNT_W  = $clog2(SCL_QTR);
	localparam logic [QCNT_W-1:0] QCNT_MAX = QCNT_W'(SCL_QTR - 1);

	localparam logic [7:0] CAM_ID = 8'h42;        // camera write address

	// camera register table, {addr, value}
	localparam int CFG_LEN   = 4;
	localparam int CFG_IDX_W = $clog2(CFG_LEN);
	localparam logic [CFG_IDX_W-1:0] CFG_LAST = CFG_IDX_W'(CFG_LEN - 1);

	localparam logic [15:0] CFG_TABLE [CFG_LEN] = '{
		16'h1280,  // com7 soft reset
		16'h1204,  // com7 rgb output
		16'h8C00,  // rgb444 off
		16'h40D0   // com15 rgb565 full range
	};

	// sccb master sequencing
	typedef enum logic [2:0] {
		IDLE,
		START,
		BITS,
		ACK,
		STOP
	} sccb_state_t;

	// configuration walker
	typedef enum logic [1:0] {
		BOOT,
		ISSUE,
		WAIT,
		DONE
	} cfg_state_t;

	// capture gating
	typedef enum logic [1:0] {
		WAIT_CFG,
		WAIT_FRAME,
		ACTIVE
	} cap_state_t;

endpackage

// File: source/cam_top.sv
`timescale 1ns/10ps

module cam_top (
	input  logic                      clk_75MHz,
	input  logic                      db_rstn,            // debounced, active low

	// camera
	input  logic                      i_cam_vsync,
	input  logic                      i_cam_href,
	input  logic                      i_cam_stb,          // byte strobe from pclk
	input  logic [7:0]                i_cam_data,

	// sccb pins, open drain
	inout  wire                       io_scl,
	inout  wire                       io_sda,

	// reader
	input  logic                      i_pix_rd,
	output logic [cam_pkg::PIX_W-1:0] o_pix_data,
	output logic                      o_pix_empty,
	output logic                      o_pix_almost_empty,

	// status
	output logic                      o_cfg_done,
	output logic                      o_capture,
	output logic                      o_overflow
);
	import cam_pkg::*;

	logic             scl_out;
	logic             sda_out;
	logic             scl_in;
	logic             sda_in;
	logic             cfg_done;
	logic             fifo_wr;
	logic [PIX_W-1:0] fifo_wdata;
	logic             fifo_full;

	// pull low or let go, pullups do the rest
	assign io_scl = scl_out ? 1'bz : 1'b0;
	assign io_sda = sda_out ? 1'bz : 1'b0;
	assign scl_in = io_scl;   // read back for clock stretch
	assign sda_in = io_sda;

	assign o_cfg_done = cfg_done;

	cam_cfg cfg_i (
		.clk_75MHz (clk_75MHz),
		.db_rstn   (db_rstn),
		.i_scl     (scl_in),
		.i_sda     (sda_in),
		.o_scl     (scl_out),
		.o_sda     (sda_out),
		.o_done    (cfg_done)
	);

	pixel_capture capture_i (
		.clk_75MHz  (clk_75MHz),
		.db_rstn    (db_rstn),
		.i_cfg_done (cfg_done),
		.i_vsync    (i_cam_vsync),
		.i_href     (i_cam_href),
		.i_stb      (i_cam_stb),
		.i_data     (i_cam_data),
		.i_full     (fifo_full),
		.o_wr       (fifo_wr),
		.o_wdata    (fifo_wdata),
		.o_status   (o_capture),
		.o_overflow (o_overflow)
	);

	pixel_fifo fifo_i (
		.clk_75MHz      (clk_75MHz),
		.db_rstn        (db_rstn),
		.i_wr           (fifo_wr),
		.i_wdata        (fifo_wdata),
		.i_rd           (i_pix_rd),
		.o_rdata        (o_pix_data),
		.o_full         (fifo_full),
		.o_empty        (o_pix_empty),
		.o_almost_empty (o_pix_almost_empty)
	);

endmodule

// File: source/pixel_capture.sv
`timescale 1ns/10ps

module pixel_capture (
	input  logic                     clk_75MHz,
	input  logic                     db_rstn,
	input  logic                     i_cfg_done,  // camera configured
	input  logic                     i_vsync,
	input  logic                     i_href,
	input  logic                     i_stb,       // one byte per pulse
	input  logic [7:0]               i_data,
	input  logic                     i_full,      // fifo full
	output logic                     o_wr,        // fifo write strobe
	output logic [cam_pkg::PIX_W-1:0] o_wdata,    // rgb444
	output logic                     o_status,    // capturing
	output logic                     o_overflow   // sticky drop flag
);
	import cam_pkg::*;

	cap_state_t state;

	logic       vsync_q;
	logic       href_q;
	logic       byte_ph;   // 1 once first byte of a pair is held
	logic [3:0] red_hi;    // r5 top bits from first byte
	logic [2:0] grn_hi;    // g6 upper bits from first byte
	logic       href_rise;
	logic       vsync_fall;
	logic       take;
	logic       pair_done;

	assign href_rise  = i_href & ~href_q;
	assign vsync_fall = vsync_q & ~i_vsync;   // frame boundary
	assign take       = (state == ACTIVE) && i_href && i_stb;
	// a byte on the href edge always starts a new pair
	assign pair_done  = take && byte_ph && !href_rise;
	assign o_status   = (state == ACTIVE);

	always_ff @(posedge clk_75MHz or negedge db_rstn) begin
		if (!db_rstn) begin
			state      <= WAIT_CFG;
			vsync_q    <= 1'b0;
			href_q     <= 1'b0;
			byte_ph    <= 1'b0;
			o_wr       <= 1'b0;
			o_overflow <= 1'b0;
		end else begin
			vsync_q <= i_vsync;
			href_q  <= i_href;
			case (state)
				WAIT_CFG:   if (i_cfg_done) state <= WAIT_FRAME;
				WAIT_FRAME: if (vsync_fall) state <= ACTIVE;
				ACTIVE:     state <= ACTIVE;
				default:    state <= WAIT_CFG;
			endcase
			if (href_rise)
				byte_ph <= take;          // drop any odd byte from last line
			else if (take)
				byte_ph <= ~byte_ph;
			o_wr <= pair_done & ~i_full;  // word lands next cycle
			if (pair_done && i_full)
				o_overflow <= 1'b1;       // word lost
		end
	end

	// pixel payload
	always_ff @(posedge clk_75MHz) begin
		if (take && !pair_done) begin
			red_hi <= i_data[7:4];
			grn_hi <= i_data[2:0];
		end
		if (pair_done)
			o_wdata <= {red_hi, grn_hi, i_data[7], i_data[4:1]};  // r4 g4 b4
	end

endmodule

// File: source/pixel_fifo.sv
`timescale 1ns/10ps

module pixel_fifo (
	input  logic                      clk_75MHz,
	input  logic                      db_rstn,
	input  logic                      i_wr,
	input  logic [cam_pkg::PIX_W-1:0] i_wdata,
	input  logic                      i_rd,            // pop head word
	output logic [cam_pkg::PIX_W-1:0] o_rdata,         // head word, fall-through
	output logic                      o_full,
	output logic                      o_empty,
	output logic                      o_almost_empty
);
	import cam_pkg::*;

	logic [PIX_W-1:0] mem [FIFO_DEPTH];

	// extra msb tells full from empty
	logic [FIFO_PTR_W:0] wptr;
	logic [FIFO_PTR_W:0] rptr;
	logic [FIFO_PTR_W:0] fill;
	logic                do_wr;
	logic                do_rd;

	assign fill    = wptr - rptr;
	assign o_empty = (wptr == rptr);
	assign o_full  = (wptr[FIFO_PTR_W] != rptr[FIFO_PTR_W]) &&
	                 (wptr[FIFO_PTR_W-1:0] == rptr[FIFO_PTR_W-1:0]);
	assign o_almost_empty = (fill <= ALMOST_EMPTY_OFS);

	assign do_wr = i_wr & ~o_full;   // ignore writes when full
	assign do_rd = i_rd & ~o_empty;

	assign o_rdata = mem[rptr[FIFO_PTR_W-1:0]];

	always_ff @(posedge clk_75MHz or negedge db_rstn) begin
		if (!db_rstn) begin
			wptr <= '0;
			rptr <= '0;
		end else begin
			if (do_wr)
				wptr <= wptr + 1'b1;
			if (do_rd)
				rptr <= rptr + 1'b1;
		end
	end

	// storage
	always_ff @(posedge clk_75MHz) begin
		if (do_wr)
			mem[wptr[FIFO_PTR_W-1:0]] <= i_wdata;
	end

endmodule

// File: source/sccb_master.sv
`timescale 1ns/10ps

module sccb_master (
	input  logic       clk_75MHz,
	input  logic       db_rstn,
	input  logic       i_cmd_stb,    // start one register write
	input  logic [7:0] i_cmd_reg,    // register address
	input  logic [7:0] i_cmd_val,    // register value
	input  logic       i_scl,        // scl read back from pin
	output logic       o_scl,        // 1 releases the line
	output logic       o_sda,        // 1 releases the line
	output logic       o_xfer_done   // one cycle after stop
);
	import cam_pkg::*;

	sccb_state_t state;

	logic [QCNT_W-1:0] qcnt;   // cycles within a quarter
	logic [1:0]        phase;  // quarter within a slot
	logic [2:0]        bit_cnt;
	logic [1:0]        byte_cnt;
	logic [23:0]       shreg;  // id, reg, val, msb first

	logic stall;
	logic qtr_end;
	logic slot_end;

	// scl released but still low, slave is holding the clock
	assign stall    = o_scl & ~i_scl;
	assign qtr_end  = !stall && (qcnt == QCNT_MAX);
	assign slot_end = qtr_end && (phase == 2'd3);

	always_ff @(posedge clk_75MHz or negedge db_rstn) begin
		if (!db_rstn) begin
			state       <= IDLE;
			qcnt        <= '0;
			phase       <= '0;
			bit_cnt     <= '0;
			byte_cnt    <= '0;
			o_xfer_done <= 1'b0;
		end else begin
			o_xfer_done <= 1'b0;
			if (state == IDLE) begin
				qcnt  <= '0;
				phase <= '0;
				if (i_cmd_stb) begin
					state    <= START;
					bit_cnt  <= '0;
					byte_cnt <= '0;
				end
			end else if (!stall) begin
				qcnt <= qtr_end ? '0 : qcnt + 1'b1;
				if (qtr_end)
					phase <= phase + 1'b1;  // wraps into next slot
				if (slot_end) begin
					case (state)
						START: state <= BITS;
						BITS: begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == 3'd7)
								state <= ACK;   // ninth bit of the byte
						end
						ACK: begin
							byte_cnt <= byte_cnt + 1'b1;
							state    <= (byte_cnt == 2'd2) ? STOP : BITS;
						end
						STOP: begin
							state       <= IDLE;
							o_xfer_done <= 1'b1;
						end
						default: state <= IDLE;
					endcase
				end
			end
		end
	end

	// shift data, loaded once per command
	always_ff @(posedge clk_75MHz) begin
		if (state == IDLE && i_cmd_stb)
			shreg <= {CAM_ID, i_cmd_reg, i_cmd_val};
		else if (state == BITS && slot_end)
			shreg <= {shreg[22:0], 1'b0};
	end

	// line levels per slot
	// data slots keep scl low in quarters 0 and 3 so sda only moves while scl is low
	always_comb begin
		o_scl = 1'b1;
		o_sda = 1'b1;
		case (state)
			START: begin
				o_scl = (phase != 2'd3);  // low only in last quarter
				o_sda = (phase == 2'd0);  // falls with scl high
			end
			BITS: begin
				o_scl = (phase == 2'd1) || (phase == 2'd2);
				o_sda = shreg[23];
			end
			ACK: begin
				o_scl = (phase == 2'd1) || (phase == 2'd2);
				o_sda = 1'b1;             // don't care bit, let go
			end
			STOP: begin
				o_scl = (phase != 2'd0);
				o_sda = phase[1];         // rises with scl high
			end
			default: ;                    // idle, both released
		endcase
	end

endmodule

// File: verif/cam_checker.sv
`timescale 1ns/10ps

module cam_checker (
	input logic                      clk_75MHz,
	input logic                      db_rstn,
	input logic                      i_pix_rd,     // reader pop
	input logic                      i_fifo_wr,    // internal fifo write
	input logic [cam_pkg::PIX_W-1:0] i_pix_data,
	input logic                      i_pix_empty,
	input logic                      i_cfg_done,
	input logic                      i_capture,
	input logic                      i_overflow
);

	// done holds until the next reset
	cfg_done_sticky: assert property (@(posedge clk_75MHz) disable iff (!db_rstn)
		!$fell(i_cfg_done)) else $error("o_cfg_done fell outside reset");

	// drop flag is sticky too
	overflow_sticky: assert property (@(posedge clk_75MHz) disable iff (!db_rstn)
		!$fell(i_overflow)) else $error("o_overflow fell outside reset");

	// no capture before the camera is set up
	capture_after_cfg: assert property (@(posedge clk_75MHz) disable iff (!db_rstn)
		i_capture |-> i_cfg_done) else $error("o_capture high without o_cfg_done");

	// head word holds while nothing moves
	head_stable: assert property (@(posedge clk_75MHz) disable iff (!db_rstn)
		(!i_pix_empty && !i_pix_rd && !i_fifo_wr) |=> $stable(i_pix_data))
		else $error("o_pix_data changed without a pop or write");

endmodule

bind cam_top cam_checker checker_i (
	.clk_75MHz   (clk_75MHz),
	.db_rstn     (db_rstn),
	.i_pix_rd    (i_pix_rd),
	.i_fifo_wr   (fifo_wr),
	.i_pix_data  (o_pix_data),
	.i_pix_empty (o_pix_empty),
	.i_cfg_done  (o_cfg_done),
	.i_capture   (o_capture),
	.i_overflow  (o_overflow)
);

// File: verif/cam_tb.sv
`timescale 1ns/10ps

module cam_tb;
	import cam_pkg::*;

	logic             clk_75MHz = 1'b0;
	logic             db_rstn   = 1'b0;
	logic             cam_vsync = 1'b0;
	logic             cam_href  = 1'b0;
	logic             cam_stb   = 1'b0;
	logic [7:0]       cam_data  = 8'h00;
	logic             pix_rd    = 1'b0;
	logic [PIX_W-1:0] pix_data;
	logic             pix_empty;
	logic             pix_almost_empty;
	logic             cfg_done;
	logic             capture;
	logic             overflow;
	wire              scl_bus;
	wire              sda_bus;

	int               err_cnt  = 0;
	int               chk_cnt  = 0;
	int               test_cnt = 0;
	logic [PIX_W-1:0] exp_q[$];   // model of fifo contents, head first

	pullup (scl_bus);
	pullup (sda_bus);

	always #20 clk_75MHz = ~clk_75MHz;  // 40 ns period

	cam_top uut (
		.clk_75MHz          (clk_75MHz),
		.db_rstn            (db_rstn),
		.i_cam_vsync        (cam_vsync),
		.i_cam_href         (cam_href),
		.i_cam_stb          (cam_stb),
		.i_cam_data         (cam_data),
		.io_scl             (scl_bus),
		.io_sda             (sda_bus),
		.i_pix_rd           (pix_rd),
		.o_pix_data         (pix_data),
		.o_pix_empty        (pix_empty),
		.o_pix_almost_empty (pix_almost_empty),
		.o_cfg_done         (cfg_done),
		.o_capture          (capture),
		.o_overflow         (overflow)
	);

	// passive sccb monitor
	logic        scl_q    = 1'b1;
	logic        sda_q    = 1'b1;
	logic        mon_busy = 1'b0;   // between start and stop
	logic        mon_bit  = 1'b0;
	logic        mon_have = 1'b0;   // sampled on rise, kept on fall
	logic [26:0] mon_bits = '0;
	int          mon_cnt  = 0;
	int          mon_bad  = 0;      // transfers with the wrong bit count
	logic [23:0] mon_xfers[$];      // {id, reg, val}

	always @(scl_bus or sda_bus) begin
		if (scl_q && scl_bus && sda_q && !sda_bus) begin  // start
			mon_busy = 1'b1;
			mon_cnt  = 0;
			mon_have = 1'b0;
		end else if (scl_q && scl_bus && !sda_q && sda_bus && mon_busy) begin  // stop
			// 3 x (8 data + 1 don't care)
			if (mon_cnt == 27)
				mon_xfers.push_back({mon_bits[26:19], mon_bits[17:10], mon_bits[8:1]});
			else
				mon_bad++;
			mon_busy = 1'b0;
		end else if (!scl_q && scl_bus) begin
			mon_bit  = sda_bus;
			mon_have = mon_busy;
		end else if (scl_q && !scl_bus && mon_have) begin
			mon_bits = {mon_bits[25:0], mon_bit};
			mon_cnt++;
			mon_have = 1'b0;
		end
		scl_q = scl_bus;
		sda_q = sda_bus;
	end

	task automatic tick();
		@(posedge clk_75MHz);
		#2;  // drive and sample just after the edge
	endtask

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("MISMATCH %s: got %0h expected %0h", name, got, exp);
		end
	endtask

	// rgb565 byte pair to rgb444
	function automatic logic [PIX_W-1:0] rgb444_of(input logic [7:0] b0, input logic [7:0] b1);
		logic [4:0] r5;
		logic [5:0] g6;
		logic [4:0] b5;
		r5 = b0[7:3];
		g6 = {b0[2:0], b1[7:5]};  // green split over both bytes
		b5 = b1[4:0];
		return {r5[4:1], g6[5:2], b5[4:1]};
	endfunction

	function automatic logic [31:0] fill_low();
		return 32'(exp_q.size() <= int'(ALMOST_EMPTY_OFS));
	endfunction

	task automatic send_byte(input logic [7:0] b);
		cam_stb  = 1'b1;
		cam_data = b;
		tick();
		cam_stb = 1'b0;
		tick();
	endtask

	task automatic pulse_vsync();
		cam_vsync = 1'b1;
		tick();
		tick();
		cam_vsync = 1'b0;  // falling edge marks the frame start
		tick();
		tick();
	endtask

	// one href line of random pairs, counted lines go into the model
	task automatic send_line(input int pairs, input bit odd_tail, input bit counted);
		logic [7:0] b0;
		logic [7:0] b1;
		cam_href = 1'b1;
		tick();
		for (int i = 0; i < pairs; i++) begin
			b0 = 8'($urandom());
			b1 = 8'($urandom());
			send_byte(b0);
			send_byte(b1);  // word already in the fifo here
			if (counted) begin
				if (exp_q.size() < FIFO_DEPTH)
					exp_q.push_back(rgb444_of(b0, b1));  // else dropped
				check_eq("o_pix_empty", 32'(pix_empty), 0);
				check_eq("o_pix_almost_empty", 32'(pix_almost_empty), fill_low());
			end
		end
		if (odd_tail)
			send_byte(8'($urandom()));  // unpaired byte
		cam_href = 1'b0;
		tick();
	endtask

	task automatic drain(input int n);
		for (int i = 0; i < n; i++) begin
			check_eq("o_pix_empty", 32'(pix_empty), 0);
			check_eq("o_pix_data", 32'(pix_data), 32'(exp_q[0]));
			pix_rd = 1'b1;
			tick();
			pix_rd = 1'b0;
			void'(exp_q.pop_front());
			check_eq("o_pix_almost_empty", 32'(pix_almost_empty), fill_low());
		end
		check_eq("o_pix_empty", 32'(pix_empty), 32'(exp_q.size() == 0));
	endtask

	task automatic end_test(input string name, input int errs_before);
		test_cnt++;
		$display("%s: %s", name, (err_cnt == errs_before) ? "ok" : "FAILED");
	endtask

	task automatic test_reset();
		int e = err_cnt;
		check_eq("o_cfg_done", 32'(cfg_done), 0);
		check_eq("o_capture", 32'(capture), 0);
		check_eq("o_overflow", 32'(overflow), 0);
		check_eq("o_pix_empty", 32'(pix_empty), 1);
		check_eq("io_scl", 32'(scl_bus), 1);
		check_eq("io_sda", 32'(sda_bus), 1);
		end_test("reset", e);
	endtask

	// camera active while config still runs
	task automatic test_early_bytes();
		int e = err_cnt;
		pulse_vsync();
		send_line(4, 1'b0, 1'b0);
		check_eq("o_cfg_done", 32'(cfg_done), 0);
		check_eq("o_capture", 32'(capture), 0);
		check_eq("o_pix_empty", 32'(pix_empty), 1);
		end_test("early_bytes", e);
	endtask

	task automatic test_config();
		int e = err_cnt;
		int n = 0;
		while (!cfg_done && n < 4000) begin
			tick();
			n++;
		end
		if (!cfg_done) begin
			err_cnt++;
			$display("timeout waiting for camera configuration to finish");
		end
		check_eq("sccb transfers", mon_xfers.size(), CFG_LEN);
		check_eq("sccb bad transfers", mon_bad, 0);
		for (int i = 0; i < CFG_LEN && i < mon_xfers.size(); i++)
			check_eq("sccb write", 32'(mon_xfers[i]), 32'({CAM_ID, CFG_TABLE[i]}));
		check_eq("io_scl", 32'(scl_bus), 1);
		check_eq("io_sda", 32'(sda_bus), 1);
		end_test("config", e);
	endtask

	task automatic test_gating();
		int e = err_cnt;
		send_line(3, 1'b0, 1'b0);  // no frame edge yet
		check_eq("o_pix_empty", 32'(pix_empty), 1);
		check_eq("o_capture", 32'(capture), 0);
		pulse_vsync();
		check_eq("o_capture", 32'(capture), 1);
		check_eq("o_pix_empty", 32'(pix_empty), 1);
		end_test("gating", e);
	endtask

	task automatic test_packing();
		int e = err_cnt;
		send_line(6, 1'b0, 1'b1);
		drain(6);
		end_test("packing", e);
	endtask

	task automatic test_overflow();
		int e = err_cnt;
		check_eq("o_overflow", 32'(overflow), 0);
		send_line(FIFO_DEPTH + 3, 1'b0, 1'b1);  // three words too many
		check_eq("o_overflow", 32'(overflow), 1);
		drain(FIFO_DEPTH);
		end_test("overflow", e);
	endtask

	task automatic test_byte_phase();
		int e = err_cnt;
		send_line(3, 1'b1, 1'b1);
		send_line(2, 1'b0, 1'b1);  // odd byte must not pair with these
		drain(5);
		end_test("byte_phase", e);
	endtask

	initial begin
		void'($urandom(32'h877c));
		repeat (16) tick();
		test_reset();
		db_rstn = 1'b1;
		test_early_bytes();
		test_config();
		test_gating();
		test_packing();
		test_overflow();
		test_byte_phase();
		$display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule
